// ==== frame_sum.f ====
verilog/frame_sum_pkg.sv
verilog/sync_fifo.sv
verilog/frame_checksum.sv
verilog/frame_sum_top.sv
bench/frame_sum_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = frame_sum_tb
FILELIST = frame_sum.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/frame_sum_tb.sv ====
module frame_sum_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import frame_sum_pkg::*;

    localparam int IN_DEPTH        = 16;
    localparam int RES_DEPTH       = 4;
    localparam int IN_AF_THRESH    = 12;
    localparam int IN_AE_THRESH    = 2;
    localparam int IN_CNT_W        = $clog2(IN_DEPTH + 1);
    localparam int RES_CNT_W       = $clog2(RES_DEPTH + 1);
    localparam int N_TESTS         = 5;
    localparam int MAX_FRAMES      = 8;
    localparam int CYCLES_PER_BYTE = 20;

    // Each row holds frame lengths and whether the host stops reading.
    typedef struct {
        string name;
        int    n_frames;
        int    lens [MAX_FRAMES];
        bit    hold_rd;
    } test_t;

    logic                   clk;
    logic                   rst_n;
    logic                   in_wr;
    beat_t                  in_beat;
    logic                   in_full;
    logic                   in_almost_full;
    logic [IN_CNT_W-1:0]    in_count;
    logic                   res_rd;
    frame_result_t          res_data;
    logic                   res_empty;
    logic [RES_CNT_W-1:0]   res_count;

    test_t         tests [N_TESTS];
    frame_result_t exp_q [$];       // Results the model expects, oldest first.
    int            pend_len;
    int            pend_sum;
    int            pend_xor;
    bit            frames_done;
    bit            writer_done;
    bit            full_seen;
    int            limit_cycles = 0;
    string         cur_name;

    frame_sum_top #(
        .IN_DEPTH     (IN_DEPTH),
        .RES_DEPTH    (RES_DEPTH),
        .IN_AF_THRESH (IN_AF_THRESH),
        .IN_AE_THRESH (IN_AE_THRESH)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_wr          (in_wr),
        .in_beat        (in_beat),
        .in_full        (in_full),
        .in_almost_full (in_almost_full),
        .in_count       (in_count),
        .res_rd         (res_rd),
        .res_data       (res_data),
        .res_empty      (res_empty),
        .res_count      (res_count)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "Stopped at first error.");
    endtask

    task automatic check_result(input string name, input frame_result_t exp,
                                input frame_result_t act);
        string exp_s;
        string act_s;
        if (act !== exp) begin
            exp_s = $sformatf("len=%0d sum=%04h par=%02h", exp.length, exp.sum, exp.parity);
            act_s = $sformatf("len=%0d sum=%04h par=%02h", act.length, act.sum, act.parity);
            stop_with_failure($sformatf("CHECK FAILED %s: expected %s, actual %s",
                                        name, exp_s, act_s));
        end
    endtask

    task automatic check_count(input string name, input logic [IN_CNT_W-1:0] exp,
                               input logic [IN_CNT_W-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED %s: expected %0d, actual %0d",
                                        name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED %s: expected %b, actual %b",
                                        name, exp, act));
        end
    endtask

    task automatic fill_table();
        tests[0] = '{"single_byte", 1, '{1, 0, 0, 0, 0, 0, 0, 0}, 1'b0};
        tests[1] = '{"frame_37", 1, '{37, 0, 0, 0, 0, 0, 0, 0}, 1'b0};
        tests[2] = '{"back_to_back", 8, '{4, 1, 9, 2, 16, 3, 7, 5}, 1'b0};
        tests[3] = '{"read_withheld", 7, '{5, 3, 6, 4, 10, 8, 7, 0}, 1'b1};
        tests[4] = '{"after_drain", 3, '{2, 12, 1, 0, 0, 0, 0, 0}, 1'b0};
    endtask

    function automatic int table_bytes();
        int total;
        total = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            for (int f = 0; f < tests[t].n_frames; f++) begin
                total += tests[t].lens[f];
            end
        end
        return total;
    endfunction

    // Reference model fed only with bytes the input FIFO took.
    task automatic model_accept(input logic [7:0] data, input logic last);
        frame_result_t exp;
        pend_len = pend_len + 1;
        pend_sum = (pend_sum + int'(data)) % 65536;
        pend_xor = pend_xor ^ int'(data);
        if (last) begin
            exp.length = 16'(pend_len);
            exp.sum    = 16'(pend_sum);
            exp.parity = 8'(pend_xor);
            exp_q.push_back(exp);
            pend_len = 0;
            pend_sum = 0;
            pend_xor = 0;
        end
    endtask

    task automatic drive_frames(input test_t t);
        logic [7:0] b;
        logic       last;
        for (int f = 0; f < t.n_frames; f++) begin
            for (int i = 0; i < t.lens[f]; i++) begin
                b    = 8'($urandom);
                last = (i == t.lens[f] - 1);
                @(posedge clk);
                in_wr   <= 1'b1;
                in_beat <= '{data: b, last: last};
                @(negedge clk);
                if (in_full) begin
                    full_seen = 1'b1;   // Dropped by the FIFO.
                end else begin
                    model_accept(b, last);
                end
            end
        end
        @(posedge clk);
        in_wr <= 1'b0;
    endtask

    // A dropped last byte leaves a frame open; end it once there is room.
    task automatic close_open_frame();
        logic [7:0] b;
        bit         accepted;
        accepted = 1'b0;
        if (pend_len != 0) begin
            b = 8'($urandom);
            while (!accepted) begin
                @(posedge clk);
                in_wr   <= 1'b1;
                in_beat <= '{data: b, last: 1'b1};
                @(negedge clk);
                accepted = !in_full;
            end
            model_accept(b, 1'b1);
            @(posedge clk);
            in_wr <= 1'b0;
        end
    endtask

    task automatic read_results(input bit hold_rd);
        frame_result_t exp;
        if (hold_rd) begin
            while (!frames_done) begin
                @(negedge clk);
            end
        end
        while (!(writer_done && exp_q.size() == 0)) begin
            @(negedge clk);
            if (!res_empty) begin
                @(posedge clk);
                res_rd <= 1'b1;
                @(posedge clk);
                res_rd <= 1'b0;
                @(negedge clk);         // Data lands after the accepted read.
                if (exp_q.size() == 0) begin
                    stop_with_failure({cur_name, ": result FIFO returned an unexpected frame"});
                end
                exp = exp_q.pop_front();
                check_result(cur_name, exp, res_data);
            end
        end
    endtask

    task automatic watch_flags();
        while (!(writer_done && exp_q.size() == 0)) begin
            @(negedge clk);
            check_flag({cur_name, " in_almost_full"},
                       int'(in_count) >= IN_AF_THRESH, in_almost_full);
            check_flag({cur_name, " in_full"}, int'(in_count) == IN_DEPTH, in_full);
            if (int'(res_count) > RES_DEPTH - 1) begin
                stop_with_failure({cur_name, ": res_count went past RES_DEPTH-1"});
            end
        end
    endtask

    task automatic check_after_reset();
        cur_name = "reset";
        check_flag("reset res_empty", 1'b1, res_empty);
        check_count("reset in_count", '0, in_count);
        check_count("reset res_count", '0, IN_CNT_W'(res_count));
        @(posedge clk);
        res_rd <= 1'b1;                 // Read from an empty queue.
        @(posedge clk);
        res_rd <= 1'b0;
        @(negedge clk);
        check_result("reset empty read", '0, res_data);
        check_count("reset res_count after read", '0, IN_CNT_W'(res_count));
        check_flag("reset res_empty after read", 1'b1, res_empty);
    endtask

    task automatic run_test(input test_t t);
        cur_name    = t.name;
        frames_done = 1'b0;
        writer_done = 1'b0;
        full_seen   = 1'b0;
        fork
            begin
                drive_frames(t);
                if (t.hold_rd) begin
                    @(negedge clk);
                    check_count({cur_name, " res_count at stall"},
                                IN_CNT_W'(RES_DEPTH - 1), IN_CNT_W'(res_count));
                    if (!full_seen) begin
                        stop_with_failure({cur_name, ": in_full never rose"});
                    end
                end
                frames_done = 1'b1;
                close_open_frame();
                writer_done = 1'b1;
            end
            read_results(t.hold_rd);
            watch_flags();
        join
        @(negedge clk);
        check_count({cur_name, " in_count idle"}, '0, in_count);
        check_count({cur_name, " res_count idle"}, '0, IN_CNT_W'(res_count));
        check_flag({cur_name, " res_empty idle"}, 1'b1, res_empty);
    endtask

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        stop_with_failure("Timeout: the tests did not finish within the cycle limit");
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_wr    = 1'b0;
        in_beat  = '0;
        res_rd   = 1'b0;
        pend_len = 0;
        pend_sum = 0;
        pend_xor = 0;
        void'($urandom(32'hf7ad_4b26));
        fill_table();
        limit_cycles = table_bytes() * CYCLES_PER_BYTE;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_after_reset();
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(tests[t]);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== verilog/frame_sum_top.sv ====
module frame_sum_top #(
    parameter int IN_DEPTH     = 16,
    parameter int RES_DEPTH    = 4,
    parameter int IN_AF_THRESH = 12,
    parameter int IN_AE_THRESH = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_wr,
    input  frame_sum_pkg::beat_t              in_beat,
    output logic                              in_full,
    output logic                              in_almost_full,
    output logic [$clog2(IN_DEPTH+1)-1:0]     in_count,
    input  logic                              res_rd,
    output frame_sum_pkg::frame_result_t      res_data,
    output logic                              res_empty,
    output logic [$clog2(RES_DEPTH+1)-1:0]    res_count
);

    import frame_sum_pkg::*;

    logic          in_empty;
    logic          pop;
    beat_t         beat;
    logic          push;
    frame_result_t result;
    logic          res_almost_full;

    sync_fifo #(
        .payload_t (beat_t),
        .DEPTH     (IN_DEPTH),
        .AF_THRESH (IN_AF_THRESH),
        .AE_THRESH (IN_AE_THRESH)
    ) i_in_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (in_wr),
        .wr_data      (in_beat),
        .rd_en        (pop),
        .rd_data      (beat),
        .full         (in_full),
        .empty        (in_empty),
        .almost_full  (in_almost_full),
        .almost_empty (),
        .count        (in_count)
    );

    frame_checksum i_engine (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_empty        (in_empty),
        .beat            (beat),
        .pop             (pop),
        .res_almost_full (res_almost_full),
        .push            (push),
        .result          (result)
    );

    // Threshold one below depth keeps a slot for the result in flight.
    sync_fifo #(
        .payload_t (frame_result_t),
        .DEPTH     (RES_DEPTH),
        .AF_THRESH (RES_DEPTH - 1),
        .AE_THRESH (1)
    ) i_res_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (push),
        .wr_data      (result),
        .rd_en        (res_rd),
        .rd_data      (res_data),
        .full         (),
        .empty        (res_empty),
        .almost_full  (res_almost_full),
        .almost_empty (),
        .count        (res_count)
    );

endmodule

// ==== verilog/frame_checksum.sv ====
module frame_checksum (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_empty,
    input  frame_sum_pkg::beat_t         beat,
    output logic                         pop,
    input  logic                         res_almost_full,
    output logic                         push,
    output frame_sum_pkg::frame_result_t result
);

    import frame_sum_pkg::*;

    logic              beat_vld;    // Registered beat is fresh.
    logic              frame_end;
    logic [LEN_W-1:0]  len_acc;
    logic [SUM_W-1:0]  sum_acc;
    logic [BYTE_W-1:0] xor_acc;
    logic [LEN_W-1:0]  len_next;
    logic [SUM_W-1:0]  sum_next;
    logic [BYTE_W-1:0] xor_next;

    assign frame_end = beat_vld && beat.last;

    // No pop in the push cycle.
    // The result FIFO then holds at most one result past its threshold.
    assign pop  = !in_empty && !res_almost_full && !frame_end;
    assign push = frame_end;

    // Totals including the beat now on the FIFO output.
    always_comb begin
        len_next = len_acc + LEN_W'(1);
        sum_next = sum_acc + SUM_W'(beat.data);
        xor_next = xor_acc ^ beat.data;
    end

    always_comb begin
        result.length = len_next;
        result.sum    = sum_next;
        result.parity = xor_next;
    end

    // FIFO read data lands one cycle after the pop.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_vld <= 1'b0;
        end else begin
            beat_vld <= pop;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_acc <= '0;
            sum_acc <= '0;
            xor_acc <= '0;
        end else if (beat_vld) begin
            if (beat.last) begin
                len_acc <= '0;      // Next frame starts clean.
                sum_acc <= '0;
                xor_acc <= '0;
            end else begin
                len_acc <= len_next;
                sum_acc <= sum_next;
                xor_acc <= xor_next;
            end
        end
    end

    // Room seen at the pop, and no other push landing before this one.
    a_push_room : assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> !$past(res_almost_full) && !res_almost_full
    ) else $error("frame_checksum push without room in result FIFO");

endmodule

// ==== verilog/sync_fifo.sv ====
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16,
    parameter int  AF_THRESH = 14,
    parameter int  AE_THRESH = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,
    input  payload_t                     wr_data,
    input  logic                         rd_en,
    output payload_t                     rd_data,
    output logic                         full,
    output logic                         empty,
    output logic                         almost_full,
    output logic                         almost_empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    // Strobes against a full or empty queue are dropped here.
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Pointer advance with wrap for any depth.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PTR_W'(1);
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= ptr_inc(wr_ptr);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= ptr_inc(rd_ptr);
        end
    end

    // Read data holds between accepted reads.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;    // Idle or both.
            endcase
        end
    end

    always_comb begin
        full         = (count == CNT_W'(DEPTH));
        empty        = (count == '0);
        almost_full  = (int'(count) >= AF_THRESH);
        almost_empty = (int'(count) <= AE_THRESH);
    end

    a_count_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(count) <= DEPTH
    ) else $error("sync_fifo count above depth");

    a_full_empty : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(full && empty)
    ) else $error("sync_fifo full and empty together");

endmodule

// ==== verilog/frame_sum_pkg.sv ====
package frame_sum_pkg;

    localparam int BYTE_W = 8;
    localparam int LEN_W  = 16;
    localparam int SUM_W  = 16;

    // One stream byte with its end-of-frame mark.
    typedef struct packed {
        logic [BYTE_W-1:0] data;
        logic              last;    // Final byte of frame.
    } beat_t;

    // Per-frame totals in 40 bits.
    typedef struct packed {
        logic [LEN_W-1:0]  length;  // Bytes in frame.
        logic [SUM_W-1:0]  sum;     // Byte sum that wraps at 2^16.
        logic [BYTE_W-1:0] parity;  // XOR of all bytes.
    } frame_result_t;

endpackage
